// ==== src/mipsDecode_consts.svh ====
/* MIPS decode constants
   Field widths, opcode and funct codes, ALU and branch condition encodings */
`ifndef MIPS_DECODE_CONSTS_SVH
`define MIPS_DECODE_CONSTS_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define LINK_REG    5'd31
`define OPCODE_W    6
`define FUNCT_W     6
`define IMM_W       16
`define TARGET_W    26

// ------------------------------
// ALU operation codes
// ------------------------------
`define ALU_OP_W    4
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_AND     4'd2
`define ALU_OR      4'd3
`define ALU_XOR     4'd4
`define ALU_NOR     4'd5
`define ALU_SLT     4'd6
`define ALU_SLTU    4'd7
`define ALU_SLL     4'd8
`define ALU_SRL     4'd9
`define ALU_SRA     4'd10
`define ALU_LUI     4'd11

// ------------------------------
// Branch conditions
// ------------------------------
`define BR_COND_W   3
`define BR_EQ       3'd0
`define BR_NE       3'd1
`define BR_LEZ      3'd2
`define BR_GTZ      3'd3
`define BR_LTZ      3'd4
`define BR_GEZ      3'd5

// ------------------------------
// Opcodes
// ------------------------------
`define OP_SPECIAL  6'h00
`define OP_REGIMM   6'h01
`define OP_J        6'h02
`define OP_JAL      6'h03
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_BLEZ     6'h06
`define OP_BGTZ     6'h07
`define OP_ADDI     6'h08
`define OP_ADDIU    6'h09
`define OP_SLTI     6'h0a
`define OP_SLTIU    6'h0b
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_XORI     6'h0e
`define OP_LUI      6'h0f
`define OP_LB       6'h20
`define OP_LH       6'h21
`define OP_LW       6'h23
`define OP_LBU      6'h24
`define OP_LHU      6'h25
`define OP_SB       6'h28
`define OP_SH       6'h29
`define OP_SW       6'h2b

// SPECIAL funct field
`define FN_SLL      6'h00
`define FN_SRL      6'h02
`define FN_SRA      6'h03
`define FN_JR       6'h08
`define FN_ADD      6'h20
`define FN_ADDU     6'h21
`define FN_SUB      6'h22
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_NOR      6'h27
`define FN_SLT      6'h2a
`define FN_SLTU     6'h2b

// REGIMM rt field
`define RT_BLTZ     5'h00
`define RT_BGEZ     5'h01

`endif

// ==== src/mipsPkg.sv ====
/* MIPS decode package
   Instruction word with its R, I and J field views */
`default_nettype none

`include "mipsDecode_consts.svh"

package mipsPkg;

	// One fetched word, read through whichever format the decoder needs
	typedef union packed {
		struct packed {
			logic [`OPCODE_W-1:0]   opcode;
			logic [`REG_ADDR_W-1:0] rs;
			logic [`REG_ADDR_W-1:0] rt;
			logic [`REG_ADDR_W-1:0] rd;
			logic [`REG_ADDR_W-1:0] shamt;
			logic [`FUNCT_W-1:0]    funct;
		} rType;
		struct packed {
			logic [`OPCODE_W-1:0]   opcode;
			logic [`REG_ADDR_W-1:0] rs;
			logic [`REG_ADDR_W-1:0] rt;
			logic [`IMM_W-1:0]      imm16;
		} iType;
		struct packed {
			logic [`OPCODE_W-1:0]   opcode;
			logic [`TARGET_W-1:0]   target26;
		} jType;
	} instrWord_u;

endpackage

`default_nettype wire

// ==== src/controlDecoder.sv ====
/* Control decoder
   Opcode, funct and rt fields to control bits, ALU op and branch condition */
`timescale 1ns/1ps
`default_nettype none

`include "mipsDecode_consts.svh"

module controlDecoder import mipsPkg::*; (
	input  instrWord_u             instr,
	output logic [`ALU_OP_W-1:0]   aluOp,
	output logic [`BR_COND_W-1:0]  brCond,
	output logic                   regDst,
	output logic                   link,
	output logic                   jump,
	output logic                   jumpReg,
	output logic                   branch,
	output logic                   memRead,
	output logic                   memWrite,
	output logic                   memToReg,
	output logic                   aluSrc,
	output logic                   regWrite,
	output logic                   zeroExtend,
	output logic                   useShamt,
	output logic                   illegal
);

	always_comb begin
		aluOp      = `ALU_ADD;
		brCond     = `BR_EQ;
		regDst     = 1'b0;
		link       = 1'b0;
		jump       = 1'b0;
		jumpReg    = 1'b0;
		branch     = 1'b0;
		memRead    = 1'b0;
		memWrite   = 1'b0;
		memToReg   = 1'b0;
		aluSrc     = 1'b0;
		regWrite   = 1'b0;
		zeroExtend = 1'b0;
		useShamt   = 1'b0;
		illegal    = 1'b0;

		case (instr.rType.opcode)
			`OP_SPECIAL: begin
				regDst   = 1'b1;
				regWrite = 1'b1;
				case (instr.rType.funct)
					`FN_ADD, `FN_ADDU: aluOp = `ALU_ADD;
					`FN_SUB, `FN_SUBU: aluOp = `ALU_SUB;
					`FN_AND:  aluOp = `ALU_AND;
					`FN_OR:   aluOp = `ALU_OR;
					`FN_XOR:  aluOp = `ALU_XOR;
					`FN_NOR:  aluOp = `ALU_NOR;
					`FN_SLT:  aluOp = `ALU_SLT;
					`FN_SLTU: aluOp = `ALU_SLTU;
					`FN_SLL, `FN_SRL, `FN_SRA: begin
						useShamt = 1'b1;
						aluOp    = (instr.rType.funct == `FN_SLL) ? `ALU_SLL :
						           (instr.rType.funct == `FN_SRL) ? `ALU_SRL : `ALU_SRA;
					end
					`FN_JR: begin
						regDst   = 1'b0;
						regWrite = 1'b0;
						jump     = 1'b1;
						jumpReg  = 1'b1;
					end
					default: begin
						regDst   = 1'b0;
						regWrite = 1'b0;
						illegal  = 1'b1;
					end
				endcase
			end

			// Sign tests on rs selected by the rt field
			`OP_REGIMM: begin
				case (instr.iType.rt)
					`RT_BLTZ: begin
						branch = 1'b1;
						brCond = `BR_LTZ;
					end
					`RT_BGEZ: begin
						branch = 1'b1;
						brCond = `BR_GEZ;
					end
					default: illegal = 1'b1;
				endcase
			end

			`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: begin
				branch = 1'b1;
				brCond = (instr.rType.opcode == `OP_BEQ) ? `BR_EQ :
				         (instr.rType.opcode == `OP_BNE) ? `BR_NE :
				         (instr.rType.opcode == `OP_BLEZ) ? `BR_LEZ : `BR_GTZ;
			end

			`OP_J: jump = 1'b1;
			`OP_JAL: begin
				jump     = 1'b1;
				link     = 1'b1;
				regWrite = 1'b1;
			end

			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU: begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				if (instr.rType.opcode == `OP_SLTI)
					aluOp = `ALU_SLT;
				else if (instr.rType.opcode == `OP_SLTIU)
					aluOp = `ALU_SLTU;
			end

			// Logical immediates are zero extended
			`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
				aluSrc     = 1'b1;
				regWrite   = 1'b1;
				zeroExtend = 1'b1;
				aluOp      = (instr.rType.opcode == `OP_ANDI) ? `ALU_AND :
				             (instr.rType.opcode == `OP_ORI) ? `ALU_OR :
				             (instr.rType.opcode == `OP_XORI) ? `ALU_XOR : `ALU_LUI;
			end

			`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				memRead  = 1'b1;
				memToReg = 1'b1;
			end

			`OP_SB, `OP_SH, `OP_SW: begin
				aluSrc   = 1'b1;
				memWrite = 1'b1;
			end

			default: illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/registerFile.sv ====
/* Register file
   32 words, two combinational reads, one clocked write-back port */
`timescale 1ns/1ps
`default_nettype none

`include "mipsDecode_consts.svh"

module registerFile (
	input  logic                    CLK,
	input  logic                    RESET,
	input  logic [`REG_ADDR_W-1:0]  rsAddr,
	input  logic [`REG_ADDR_W-1:0]  rtAddr,
	input  logic                    wbEnable,
	input  logic [`REG_ADDR_W-1:0]  wbReg,
	input  logic [`WORD_W-1:0]      wbData,
	output logic [`WORD_W-1:0]      rsData,
	output logic [`WORD_W-1:0]      rtData
);

	logic [`WORD_W-1:0] regs [`NUM_REGS];

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wbEnable && (wbReg != '0)) begin
			regs[wbReg] <= wbData;
		end
	end

	// r0 is hardwired to zero
	assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

`default_nettype wire

// ==== src/branchResolver.sv ====
/* Branch resolver
   Evaluates the branch condition and picks the next instruction address */
`timescale 1ns/1ps
`default_nettype none

`include "mipsDecode_consts.svh"

module branchResolver import mipsPkg::*; (
	input  instrWord_u              instr,
	input  logic [`WORD_W-1:0]      pcPlus4,
	input  logic [`WORD_W-1:0]      rsData,
	input  logic [`WORD_W-1:0]      rtData,
	input  logic                    branch,
	input  logic                    jump,
	input  logic                    jumpReg,
	input  logic [`BR_COND_W-1:0]   brCond,
	output logic                    taken,
	output logic [`WORD_W-1:0]      nextPc
);

	logic               condTrue;
	logic               rsZero;
	logic               rsNeg;
	logic [`WORD_W-1:0] branchTarget;
	logic [`WORD_W-1:0] jumpTarget;

	assign rsZero = (rsData == '0);
	assign rsNeg  = rsData[`WORD_W-1];

	always_comb begin
		case (brCond)
			`BR_EQ:  condTrue = (rsData == rtData);
			`BR_NE:  condTrue = (rsData != rtData);
			`BR_LEZ: condTrue = rsNeg || rsZero;
			`BR_GTZ: condTrue = !rsNeg && !rsZero;
			`BR_LTZ: condTrue = rsNeg;
			`BR_GEZ: condTrue = !rsNeg;
			default: condTrue = 1'b0;
		endcase
	end

	// Word offset relative to the delay slot
	assign branchTarget = pcPlus4 + {{(`WORD_W-`IMM_W-2){instr.iType.imm16[`IMM_W-1]}},
	                                 instr.iType.imm16, 2'b00};

	// Region of the delay slot plus the word target
	assign jumpTarget = {pcPlus4[`WORD_W-1:`TARGET_W+2], instr.jType.target26, 2'b00};

	assign taken  = jump || (branch && condTrue);
	assign nextPc = jump ? (jumpReg ? rsData : jumpTarget) :
	                taken ? branchTarget : pcPlus4;

endmodule

`default_nettype wire

// ==== src/idExRegister.sv ====
/* ID/EX pipeline register
   Forms execute operands and holds one decoded instruction under valid/ready */
`timescale 1ns/1ps
`default_nettype none

`include "mipsDecode_consts.svh"

module idExRegister import mipsPkg::*; (
	input  logic                    CLK,
	input  logic                    RESET,
	input  logic                    instrValid,
	input  logic                    exReady,
	input  instrWord_u              instr,
	input  logic [`WORD_W-1:0]      pcPlus4,
	input  logic [`WORD_W-1:0]      rsData,
	input  logic [`WORD_W-1:0]      rtData,
	input  logic [`ALU_OP_W-1:0]    aluOp,
	input  logic                    regDst,
	input  logic                    link,
	input  logic                    memRead,
	input  logic                    memWrite,
	input  logic                    memToReg,
	input  logic                    aluSrc,
	input  logic                    regWrite,
	input  logic                    zeroExtend,
	input  logic                    useShamt,
	input  logic                    illegal,
	input  logic                    taken,
	input  logic [`WORD_W-1:0]      nextPc,
	output logic                    instrReady,
	output logic                    exValid,
	output logic [`ALU_OP_W-1:0]    exAluOp,
	output logic [`WORD_W-1:0]      exOperandA,
	output logic [`WORD_W-1:0]      exOperandB,
	output logic [`WORD_W-1:0]      exStoreData,
	output logic [`REG_ADDR_W-1:0]  exWriteReg,
	output logic                    exWriteEnable,
	output logic                    exMemRead,
	output logic                    exMemWrite,
	output logic                    exMemToReg,
	output logic                    exTaken,
	output logic [`WORD_W-1:0]      exNextPc,
	output logic                    exIllegal
);

	logic                   accept;
	logic [`WORD_W-1:0]     immExt;
	logic [`WORD_W-1:0]     operandA;
	logic [`WORD_W-1:0]     operandB;
	logic [`REG_ADDR_W-1:0] writeReg;

	// ------------------------------
	// Handshake
	// ------------------------------
	assign instrReady = !exValid || exReady;
	assign accept     = instrValid && instrReady;

	// ------------------------------
	// Operand forming
	// ------------------------------
	assign immExt = zeroExtend ?
	                {{(`WORD_W-`IMM_W){1'b0}}, instr.iType.imm16} :
	                {{(`WORD_W-`IMM_W){instr.iType.imm16[`IMM_W-1]}}, instr.iType.imm16};

	// Link writes pcPlus4 + 4 as the return address
	assign operandA = link ? pcPlus4 :
	                  useShamt ? {{(`WORD_W-`REG_ADDR_W){1'b0}}, instr.rType.shamt} : rsData;
	assign operandB = link ? `WORD_W'd4 :
	                  aluSrc ? immExt : rtData;

	assign writeReg = regDst ? instr.rType.rd :
	                  link ? `LINK_REG : instr.rType.rt;

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			exValid       <= 1'b0;
			exAluOp       <= '0;
			exWriteReg    <= '0;
			exWriteEnable <= 1'b0;
			exMemRead     <= 1'b0;
			exMemWrite    <= 1'b0;
			exMemToReg    <= 1'b0;
			exTaken       <= 1'b0;
			exIllegal     <= 1'b0;
		end else if (accept) begin
			exValid       <= 1'b1;
			exAluOp       <= aluOp;
			exWriteReg    <= writeReg;
			exWriteEnable <= regWrite && (writeReg != '0);
			exMemRead     <= memRead;
			exMemWrite    <= memWrite;
			exMemToReg    <= memToReg;
			exTaken       <= taken;
			exIllegal     <= illegal;
		end else if (exReady) begin
			exValid       <= 1'b0;
		end
	end

	// Data words
	always_ff @(posedge CLK) begin
		if (accept) begin
			exOperandA  <= operandA;
			exOperandB  <= operandB;
			exStoreData <= rtData;
			exNextPc    <= nextPc;
		end
	end

	// A stalled item stays presented until execute takes it
	stallHoldsValid: assert property (@(posedge CLK) disable iff (!RESET)
		exValid && !exReady |=> exValid);

endmodule

`default_nettype wire

// ==== src/decodeStage.sv ====
/* MIPS decode stage
   Control decoder, register file, branch resolver and ID/EX register */
`timescale 1ns/1ps
`default_nettype none

`include "mipsDecode_consts.svh"

module decodeStage import mipsPkg::*; (
	input  logic                    CLK,
	input  logic                    RESET,
	input  logic                    instrValid,
	input  instrWord_u              instr,
	input  logic [`WORD_W-1:0]      pcPlus4,
	input  logic                    exReady,
	input  logic                    wbEnable,
	input  logic [`REG_ADDR_W-1:0]  wbReg,
	input  logic [`WORD_W-1:0]      wbData,
	output logic                    instrReady,
	output logic                    exValid,
	output logic [`ALU_OP_W-1:0]    exAluOp,
	output logic [`WORD_W-1:0]      exOperandA,
	output logic [`WORD_W-1:0]      exOperandB,
	output logic [`WORD_W-1:0]      exStoreData,
	output logic [`REG_ADDR_W-1:0]  exWriteReg,
	output logic                    exWriteEnable,
	output logic                    exMemRead,
	output logic                    exMemWrite,
	output logic                    exMemToReg,
	output logic                    exTaken,
	output logic [`WORD_W-1:0]      exNextPc,
	output logic                    exIllegal
);

	logic [`ALU_OP_W-1:0]  aluOp;
	logic [`BR_COND_W-1:0] brCond;
	logic                  regDst;
	logic                  link;
	logic                  jump;
	logic                  jumpReg;
	logic                  branch;
	logic                  memRead;
	logic                  memWrite;
	logic                  memToReg;
	logic                  aluSrc;
	logic                  regWrite;
	logic                  zeroExtend;
	logic                  useShamt;
	logic                  illegal;
	logic [`WORD_W-1:0]    rsData;
	logic [`WORD_W-1:0]    rtData;
	logic                  taken;
	logic [`WORD_W-1:0]    nextPc;

	controlDecoder decoder (
		.instr(instr), .aluOp(aluOp), .brCond(brCond), .regDst(regDst), .link(link),
		.jump(jump), .jumpReg(jumpReg), .branch(branch), .memRead(memRead),
		.memWrite(memWrite), .memToReg(memToReg), .aluSrc(aluSrc), .regWrite(regWrite),
		.zeroExtend(zeroExtend), .useShamt(useShamt), .illegal(illegal)
	);

	registerFile regFile (
		.CLK(CLK), .RESET(RESET), .rsAddr(instr.rType.rs), .rtAddr(instr.rType.rt),
		.wbEnable(wbEnable), .wbReg(wbReg), .wbData(wbData),
		.rsData(rsData), .rtData(rtData)
	);

	branchResolver resolver (
		.instr(instr), .pcPlus4(pcPlus4), .rsData(rsData), .rtData(rtData),
		.branch(branch), .jump(jump), .jumpReg(jumpReg), .brCond(brCond),
		.taken(taken), .nextPc(nextPc)
	);

	idExRegister pipeReg (
		.CLK(CLK), .RESET(RESET), .instrValid(instrValid), .exReady(exReady),
		.instr(instr), .pcPlus4(pcPlus4), .rsData(rsData), .rtData(rtData),
		.aluOp(aluOp), .regDst(regDst), .link(link), .memRead(memRead),
		.memWrite(memWrite), .memToReg(memToReg), .aluSrc(aluSrc), .regWrite(regWrite),
		.zeroExtend(zeroExtend), .useShamt(useShamt), .illegal(illegal),
		.taken(taken), .nextPc(nextPc), .instrReady(instrReady), .exValid(exValid),
		.exAluOp(exAluOp), .exOperandA(exOperandA), .exOperandB(exOperandB),
		.exStoreData(exStoreData), .exWriteReg(exWriteReg), .exWriteEnable(exWriteEnable),
		.exMemRead(exMemRead), .exMemWrite(exMemWrite), .exMemToReg(exMemToReg),
		.exTaken(exTaken), .exNextPc(exNextPc), .exIllegal(exIllegal)
	);

endmodule

`default_nettype wire

// ==== testbench/decodeStageTb.sv ====
/* Decode stage testbench
   Random instructions under valid/ready, checked against a reference model */
`timescale 1ns/1ps
`default_nettype none

`include "mipsDecode_consts.svh"

module decodeStageTb import mipsPkg::*; ;

	localparam int NUM_INSTR  = 2000;
	localparam int MAX_CYCLES = 3 * NUM_INSTR + 100;

	typedef struct packed {
		logic [`ALU_OP_W-1:0]   aluOp;
		logic                   we;
		logic                   mr;
		logic                   mw;
		logic                   m2r;
		logic                   ill;
		logic                   taken;
		logic [`WORD_W-1:0]     opA;
		logic [`WORD_W-1:0]     opB;
		logic [`WORD_W-1:0]     store;
		logic [`REG_ADDR_W-1:0] wr;
		logic [`WORD_W-1:0]     next;
	} expItem_t;

	logic                   CLK;
	logic                   RESET;
	logic                   instrValid;
	instrWord_u             instr;
	logic [`WORD_W-1:0]     pcPlus4;
	logic                   exReady;
	logic                   wbEnable;
	logic [`REG_ADDR_W-1:0] wbReg;
	logic [`WORD_W-1:0]     wbData;
	logic                   instrReady;
	logic                   exValid;
	logic [`ALU_OP_W-1:0]   exAluOp;
	logic [`WORD_W-1:0]     exOperandA;
	logic [`WORD_W-1:0]     exOperandB;
	logic [`WORD_W-1:0]     exStoreData;
	logic [`REG_ADDR_W-1:0] exWriteReg;
	logic                   exWriteEnable;
	logic                   exMemRead;
	logic                   exMemWrite;
	logic                   exMemToReg;
	logic                   exTaken;
	logic [`WORD_W-1:0]     exNextPc;
	logic                   exIllegal;

	integer             seed;
	int                 cycles = 0;
	int                 accepted;
	int                 retired;
	logic [`WORD_W-1:0] modelRegs [`NUM_REGS];
	expItem_t           expQ [$];

	logic [`FUNCT_W-1:0] specialFn [14] = '{`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND,
		`FN_OR, `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU, `FN_SLL, `FN_SRL, `FN_SRA, `FN_JR};
	logic [`OPCODE_W-1:0] otherOp [22] = '{`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
		`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI, `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU,
		`OP_SB, `OP_SH, `OP_SW, `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_J, `OP_JAL};

	decodeStage u_dut (
		.CLK(CLK), .RESET(RESET), .instrValid(instrValid), .instr(instr),
		.pcPlus4(pcPlus4), .exReady(exReady), .wbEnable(wbEnable), .wbReg(wbReg),
		.wbData(wbData), .instrReady(instrReady), .exValid(exValid), .exAluOp(exAluOp),
		.exOperandA(exOperandA), .exOperandB(exOperandB), .exStoreData(exStoreData),
		.exWriteReg(exWriteReg), .exWriteEnable(exWriteEnable), .exMemRead(exMemRead),
		.exMemWrite(exMemWrite), .exMemToReg(exMemToReg), .exTaken(exTaken),
		.exNextPc(exNextPc), .exIllegal(exIllegal)
	);

	always #20 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			stopOnFailure("Timeout: the stage stopped moving instructions");
	end

	// ------------------------------
	// Failure reporting and checks
	// ------------------------------
	task automatic stopOnFailure(string reason);
		$display("Regression failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic checkControl(string name, logic [`ALU_OP_W+4:0] expected,
			logic [`ALU_OP_W+4:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			stopOnFailure({"Control mismatch in ", name});
		end
	endtask

	task automatic checkOperands(string name, logic [`WORD_W-1:0] expected,
			logic [`WORD_W-1:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			stopOnFailure({"Operand mismatch in ", name});
		end
	endtask

	task automatic checkFlow(string name, logic expTaken, logic [`WORD_W-1:0] expNext,
			logic actTaken, logic [`WORD_W-1:0] actNext);
		if (actTaken !== expTaken || actNext !== expNext) begin
			$display("ERROR %s: expected %b/%h, actual %b/%h", name, expTaken, expNext,
			         actTaken, actNext);
			stopOnFailure({"Flow mismatch in ", name});
		end
	endtask

	task automatic checkHandshake(string name, logic [1:0] expected, logic [1:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %b, actual %b", name, expected, actual);
			stopOnFailure({"Handshake mismatch in ", name});
		end
	endtask

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic expItem_t expectItem(instrWord_u w, logic [`WORD_W-1:0] pc,
			logic [`WORD_W-1:0] rsVal, logic [`WORD_W-1:0] rtVal);
		expItem_t           e;
		logic [`WORD_W-1:0] sImm;
		logic [`WORD_W-1:0] zImm;
		logic               writes;
		logic               isBranch;
		sImm = {{16{w.iType.imm16[15]}}, w.iType.imm16};
		zImm = {16'b0, w.iType.imm16};
		e = '0;
		e.aluOp = `ALU_ADD;
		e.opA = rsVal;
		e.opB = rtVal;
		e.store = rtVal;
		e.wr = w.iType.rt;
		e.next = pc;
		writes = 1'b0;
		isBranch = 1'b0;
		case (w.rType.opcode)
			`OP_SPECIAL: begin
				e.wr = w.rType.rd;
				writes = 1'b1;
				case (w.rType.funct)
					`FN_SUB, `FN_SUBU: e.aluOp = `ALU_SUB;
					`FN_AND:  e.aluOp = `ALU_AND;
					`FN_OR:   e.aluOp = `ALU_OR;
					`FN_XOR:  e.aluOp = `ALU_XOR;
					`FN_NOR:  e.aluOp = `ALU_NOR;
					`FN_SLT:  e.aluOp = `ALU_SLT;
					`FN_SLTU: e.aluOp = `ALU_SLTU;
					`FN_ADD, `FN_ADDU: e.aluOp = `ALU_ADD;
					`FN_SLL: begin
						e.opA = {27'b0, w.rType.shamt};
						e.aluOp = `ALU_SLL;
					end
					`FN_SRL: begin
						e.opA = {27'b0, w.rType.shamt};
						e.aluOp = `ALU_SRL;
					end
					`FN_SRA: begin
						e.opA = {27'b0, w.rType.shamt};
						e.aluOp = `ALU_SRA;
					end
					`FN_JR: begin
						e.wr = w.rType.rt;
						writes = 1'b0;
						e.taken = 1'b1;
						e.next = rsVal;
					end
					default: begin
						writes = 1'b0;
						e.ill = 1'b1;
					end
				endcase
			end
			`OP_REGIMM: begin
				isBranch = 1'b1;
				if (w.iType.rt == `RT_BLTZ)
					e.taken = $signed(rsVal) < 0;
				else if (w.iType.rt == `RT_BGEZ)
					e.taken = $signed(rsVal) >= 0;
				else
					e.ill = 1'b1;
			end
			`OP_BEQ: begin
				isBranch = 1'b1;
				e.taken = (rsVal == rtVal);
			end
			`OP_BNE: begin
				isBranch = 1'b1;
				e.taken = (rsVal != rtVal);
			end
			`OP_BLEZ: begin
				isBranch = 1'b1;
				e.taken = $signed(rsVal) <= 0;
			end
			`OP_BGTZ: begin
				isBranch = 1'b1;
				e.taken = $signed(rsVal) > 0;
			end
			`OP_J, `OP_JAL: begin
				e.taken = 1'b1;
				e.next = {pc[31:28], w.jType.target26, 2'b00};
				if (w.jType.opcode == `OP_JAL) begin
					e.opA = pc;
					e.opB = 32'd4;
					e.wr = `LINK_REG;
					writes = 1'b1;
				end
			end
			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU: begin
				e.opB = sImm;
				writes = 1'b1;
				if (w.iType.opcode == `OP_SLTI)
					e.aluOp = `ALU_SLT;
				else if (w.iType.opcode == `OP_SLTIU)
					e.aluOp = `ALU_SLTU;
			end
			`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
				e.opB = zImm;
				writes = 1'b1;
				case (w.iType.opcode)
					`OP_ANDI: e.aluOp = `ALU_AND;
					`OP_ORI:  e.aluOp = `ALU_OR;
					`OP_XORI: e.aluOp = `ALU_XOR;
					default:  e.aluOp = `ALU_LUI;
				endcase
			end
			`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
				e.opB = sImm;
				e.mr = 1'b1;
				e.m2r = 1'b1;
				writes = 1'b1;
			end
			`OP_SB, `OP_SH, `OP_SW: begin
				e.opB = sImm;
				e.mw = 1'b1;
			end
			default: e.ill = 1'b1;
		endcase
		if (e.ill)
			e.taken = 1'b0;
		if (isBranch && e.taken)
			e.next = pc + (sImm << 2);
		e.we = writes && (e.wr != '0);
		return e;
	endfunction

	// ------------------------------
	// Stimulus
	// ------------------------------
	task automatic pickInstr(output instrWord_u w);
		int         sel;
		logic [31:0] r;
		w = $random(seed);
		sel = {$random(seed)} % 40;
		r = $random(seed);
		if (sel < 14) begin
			w.rType.opcode = `OP_SPECIAL;
			w.rType.funct = specialFn[sel];
		end else if (sel < 36) begin
			w.rType.opcode = otherOp[sel - 14];
		end else if (sel < 38) begin
			w.iType.opcode = `OP_REGIMM;
			w.iType.rt = (sel == 36) ? `RT_BLTZ : `RT_BGEZ;
		end else if (sel == 38) begin
			w.rType.opcode = 6'h3f;
		end else begin
			// Syscall funct, no longer decoded
			w.rType.opcode = `OP_SPECIAL;
			w.rType.funct = 6'h0c;
		end
		// Equal compares are rare with random registers
		if (r[1:0] == 2'b00 && (w.rType.opcode == `OP_BEQ || w.rType.opcode == `OP_BNE))
			w.iType.rt = w.iType.rs;
	endtask

	task automatic stepInputs();
		instrWord_u  w;
		expItem_t    e;
		logic        readyNow;
		logic [31:0] r;
		pickInstr(w);
		instr = w;
		pcPlus4 = $random(seed);
		r = $random(seed);
		instrValid = (accepted < NUM_INSTR) && (r[1:0] != 2'b00);
		exReady = (r[3:2] != 2'b00);
		wbEnable = r[4];
		wbReg = r[9:5];
		wbData = $random(seed);

		// Model state as of the next rising edge
		readyNow = (expQ.size() == 0) || exReady;
		if (expQ.size() != 0 && exReady) begin
			void'(expQ.pop_front());
			retired++;
		end
		if (instrValid && readyNow) begin
			e = expectItem(w, pcPlus4, modelRegs[w.rType.rs], modelRegs[w.rType.rt]);
			expQ.push_back(e);
			accepted++;
		end
		if (wbEnable && wbReg != '0)
			modelRegs[wbReg] = wbData;
	endtask

	task automatic checkPresented();
		expItem_t e;
		string    tag;
		if (expQ.size() == 0)
			return;
		e = expQ[0];
		tag = $sformatf("item %0d", retired);
		checkControl({tag, " control"}, {e.aluOp, e.we, e.mr, e.mw, e.m2r, e.ill},
			{exAluOp, exWriteEnable, exMemRead, exMemWrite, exMemToReg, exIllegal});
		checkFlow({tag, " flow"}, e.taken, e.next, exTaken, exNextPc);
		if (!e.ill) begin
			checkOperands({tag, " operandA"}, e.opA, exOperandA);
			checkOperands({tag, " operandB"}, e.opB, exOperandB);
			checkOperands({tag, " store data"}, e.store, exStoreData);
			checkOperands({tag, " write register"}, {27'b0, e.wr}, {27'b0, exWriteReg});
		end
	endtask

	initial begin
		seed = 82860;
		CLK = 1'b0;
		RESET = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		pcPlus4 = '0;
		exReady = 1'b0;
		wbEnable = 1'b0;
		wbReg = '0;
		wbData = '0;
		accepted = 0;
		retired = 0;
		for (int i = 0; i < `NUM_REGS; i++)
			modelRegs[i] = '0;

		repeat (16) @(posedge CLK);
		@(negedge CLK);
		checkHandshake("reset", 2'b01, {exValid, instrReady});
		checkControl("reset", '0,
			{exAluOp, exWriteEnable, exMemRead, exMemWrite, exMemToReg, exIllegal});
		if (exTaken !== 1'b0)
			stopOnFailure("exTaken is not cleared by reset");
		RESET = 1'b1;

		while (accepted < NUM_INSTR || expQ.size() != 0) begin
			@(negedge CLK);
			checkPresented();
			checkHandshake($sformatf("handshake at cycle %0d", cycles),
				{expQ.size() != 0, expQ.size() == 0 || exReady}, {exValid, instrReady});
			stepInputs();
		end

		// Stage empty once the last item has left
		@(negedge CLK);
		checkHandshake("drain", 2'b01, {exValid, instrReady});
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/mipsPkg.sv
src/controlDecoder.sv
src/registerFile.sv
src/branchResolver.sv
src/idExRegister.sv
src/decodeStage.sv
testbench/decodeStageTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f files.f \
	--top-module decodeStageTb \
	-o decodeStageSim

./obj_dir/decodeStageSim
